// ==== jtag_stimulus.txt ====
# op count tdi chain expect mask sel : count decimal, other columns hex, TDO expect LSB first
# irscan tdi is the instruction code; sel bits are extest sample_preload mbist debug
drscan   32 00000000 00 5A3C96E1 FFFFFFFF 0
irscan    4 F        00 5        F        0
drscan    8 B4       00 68       FE       0
irscan    4 6        00 5        F        0
drscan    6 2D       00 1A       3E       0
irscan    4 C        00 5        F        0
drscan    8 5B       00 5B       FF       0
irscan    4 0        00 5        F        8
drscan    8 A5       1E E1       FF       8
irscan    4 1        00 5        F        4
drscan    8 A5       1E E1       FF       4
irscan    4 9        00 5        F        2
drscan    8 A5       1E 78       FF       2
irscan    4 8        00 5        F        1
drscan    8 A5       1E 1E       FF       1
tmsreset  5 0        00 0        0        0
drscan   32 FFFFFFFF 00 5A3C96E1 FFFFFFFF 0
irscan    4 2        00 5        F        0
drscan   32 00000000 00 5A3C96E1 FFFFFFFF 0

// ==== filelist.f ====
jtag_pkg.sv
tap_state_if.sv
tap_fsm.sv
tap_instruction_reg.sv
tap_data_regs.sv
tap_tdo_mux.sv
jtag_tap.sv
tb_clock_gen.sv
tb_jtag_tap.sv

// ==== Makefile ====
# Verilator build and run of the JTAG TAP testbench

obj_dir/Vtb_jtag_tap: filelist.f $(wildcard *.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module tb_jtag_tap -f filelist.f

run: obj_dir/Vtb_jtag_tap
	./obj_dir/Vtb_jtag_tap | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== tb_jtag_tap.sv ====
// Testbench for the JTAG TAP controller
// Reads scan operations from the stimulus file, walks the TAP through
// IR scans, DR scans and TMS resets, checks TDO, output enable and selects

`timescale 1ns/1ps

module tb_jtag_tap;

  // Device code the stimulus file expects back from the DUT
  localparam logic [31:0] IDCODE_VALUE = 32'h5A3C96E1;

  logic tck;
  logic trst_pad_i;
  logic tms_pad_i;
  logic tdi_pad_i;
  logic debug_tdi_i;
  logic bs_chain_tdi_i;
  logic mbist_tdi_i;
  logic tdo_pad_o;
  logic tdo_padoe_o;
  logic shift_dr_o;
  logic pause_dr_o;
  logic update_dr_o;
  logic capture_dr_o;
  logic test_logic_reset_o;
  logic extest_select_o;
  logic sample_preload_select_o;
  logic mbist_select_o;
  logic debug_select_o;
  logic tdo_o;

  // Operations from the file with one entry per line
  string       op_q[$];
  int          count_q[$];
  logic [31:0] tdi_q[$];
  logic [31:0] chain_q[$];
  logic [31:0] exp_q[$];
  logic [31:0] mask_q[$];
  logic [3:0]  sel_q[$];

  int cycle_count = 0;
  int cycle_limit = 0;
  int fail_count  = 0;

  tb_clock_gen #(.period_ns(100)) clock_gen (.clk_o(tck));

  jtag_tap #(.idcode_value(IDCODE_VALUE)) jtag_tap_inst (
    .tck_pad_i(tck), .trst_pad_i(trst_pad_i), .tms_pad_i(tms_pad_i),
    .tdi_pad_i(tdi_pad_i), .tdo_pad_o(tdo_pad_o), .tdo_padoe_o(tdo_padoe_o),
    .shift_dr_o(shift_dr_o), .pause_dr_o(pause_dr_o), .update_dr_o(update_dr_o),
    .capture_dr_o(capture_dr_o), .test_logic_reset_o(test_logic_reset_o),
    .extest_select_o(extest_select_o), .sample_preload_select_o(sample_preload_select_o),
    .mbist_select_o(mbist_select_o), .debug_select_o(debug_select_o), .tdo_o(tdo_o),
    .debug_tdi_i(debug_tdi_i), .bs_chain_tdi_i(bs_chain_tdi_i), .mbist_tdi_i(mbist_tdi_i)
  );

  //////////////////////////////////////////////////
  // Failure handling and checks
  //////////////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_level(input logic actual, input logic expected, input string what);
    assert (actual === expected)
    else
    begin
      fail_count++;
      report_failure($sformatf("error at %0t ns: %s is %b, expected %b",
                               $time, what, actual, expected));
    end
  endtask

  // Selects and state levels in an idle TLR or RTI cycle
  task automatic check_idle(input logic [3:0] sel, input logic tlr);
    check_level(extest_select_o, sel[3], "extest_select_o");
    check_level(sample_preload_select_o, sel[2], "sample_preload_select_o");
    check_level(mbist_select_o, sel[1], "mbist_select_o");
    check_level(debug_select_o, sel[0], "debug_select_o");
    check_level(test_logic_reset_o, tlr, "test_logic_reset_o");
    check_level(capture_dr_o, 1'b0, "capture_dr_o while idle");
    check_level(update_dr_o, 1'b0, "update_dr_o while idle");
    check_level(tdo_padoe_o, 1'b0, "tdo_padoe_o while idle");
  endtask

  // Stop a run that outlasts twice its planned length
  always @(posedge tck)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit)
      report_failure($sformatf("timeout: run passed its limit of %0d cycles", cycle_limit));
  end

  //////////////////////////////////////////////////
  // TAP sequencing
  //////////////////////////////////////////////////

  // Drive one TCK cycle 5 ns after the edge, return 5 ns before the next
  task automatic run_cycle(input logic tms, input logic tdi, input logic dbg,
                           input logic bs, input logic mb);
    @(posedge tck);
    #5;
    tms_pad_i      = tms;
    tdi_pad_i      = tdi;
    debug_tdi_i    = dbg;
    bs_chain_tdi_i = bs;
    mbist_tdi_i    = mb;
    #90;
  endtask

  task automatic step_tms(input logic tms);
    run_cycle(tms, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  // One bit per shift cycle and TMS high on the last bit
  // Debug chain gets the chain word, boundary scan its inverse,
  // MBIST the word in reverse order
  task automatic shift_bits(input int count, input logic [31:0] tdi, input logic [31:0] chain,
                            input logic [31:0] exp, input logic [31:0] mask, input logic dr);
    for (int i = 0; i < count; i++)
    begin
      run_cycle(i == count - 1, tdi[i], chain[i], ~chain[i], chain[count-1-i]);
      if (mask[i])
        check_level(tdo_pad_o, exp[i], $sformatf("tdo_pad_o bit %0d", i));
      check_level(tdo_padoe_o, 1'b1, "tdo_padoe_o while shifting");
      check_level(shift_dr_o, dr, "shift_dr_o");
      check_level(tdo_o, tdi[i], "tdo_o feedthrough");
    end
  endtask

  task automatic scan_ir(input int k);
    // RTI, Select-DR, Select-IR, Capture-IR
    step_tms(1'b1);
    step_tms(1'b1);
    step_tms(1'b0);
    step_tms(1'b0);
    shift_bits(count_q[k], tdi_q[k], chain_q[k], exp_q[k], mask_q[k], 1'b0);
    // Exit1-IR and Update-IR
    step_tms(1'b1);
    step_tms(1'b0);
    // New instruction active in RTI
    step_tms(1'b0);
    check_idle(sel_q[k], 1'b0);
  endtask

  task automatic scan_dr(input int k);
    step_tms(1'b1);
    step_tms(1'b0);
    step_tms(1'b0);
    check_level(capture_dr_o, 1'b1, "capture_dr_o");
    shift_bits(count_q[k], tdi_q[k], chain_q[k], exp_q[k], mask_q[k], 1'b1);
    // Exit1-DR into Pause-DR where only DEBUG keeps the pad on
    step_tms(1'b0);
    step_tms(1'b1);
    check_level(pause_dr_o, 1'b1, "pause_dr_o");
    check_level(tdo_padoe_o, sel_q[k][0], "tdo_padoe_o in Pause-DR");
    // Exit2-DR and Update-DR
    step_tms(1'b1);
    step_tms(1'b0);
    check_level(update_dr_o, 1'b1, "update_dr_o");
    // Back to RTI
    step_tms(1'b0);
    check_idle(sel_q[k], 1'b0);
  endtask

  // Park in Shift-DR before a run of TMS ones
  task automatic force_reset_tms(input int k);
    step_tms(1'b1);
    step_tms(1'b0);
    step_tms(1'b0);
    repeat (count_q[k])
      step_tms(1'b1);
    step_tms(1'b0);
    check_level(test_logic_reset_o, 1'b1, "test_logic_reset_o after TMS ones");
    step_tms(1'b0);
    check_idle(sel_q[k], 1'b0);
  endtask

  //////////////////////////////////////////////////
  // Stimulus file
  //////////////////////////////////////////////////

  task automatic load_stimulus(output int total);
    int          fd;
    int          fields;
    string       line;
    string       op;
    int          count;
    logic [31:0] tdi;
    logic [31:0] chain;
    logic [31:0] exp;
    logic [31:0] mask;
    logic [3:0]  sel;
    total = 0;
    fd = $fopen("jtag_stimulus.txt", "r");
    if (fd == 0)
      report_failure("the stimulus file jtag_stimulus.txt could not be opened");
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        // Skip blank and comment lines
        if (line.len() > 1 && line.getc(0) != "#")
        begin
          fields = $sscanf(line, "%s %d %h %h %h %h %h", op, count, tdi, chain, exp, mask, sel);
          if (fields != 7)
            report_failure($sformatf("malformed stimulus line: %s", line));
          else if (op != "irscan" && op != "drscan" && op != "tmsreset")
            report_failure($sformatf("unknown stimulus operation: %s", op));
          else
          begin
            op_q.push_back(op);
            count_q.push_back(count);
            tdi_q.push_back(tdi);
            chain_q.push_back(chain);
            exp_q.push_back(exp);
            mask_q.push_back(mask);
            sel_q.push_back(sel);
            // Cycles per operation around its shift or TMS run
            if (op == "irscan")
              total += count + 7;
            else if (op == "drscan")
              total += count + 8;
            else
              total += count + 5;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial
  begin
    int total;
    trst_pad_i     = 1'b1;
    tms_pad_i      = 1'b0;
    tdi_pad_i      = 1'b0;
    debug_tdi_i    = 1'b0;
    bs_chain_tdi_i = 1'b0;
    mbist_tdi_i    = 1'b0;
    load_stimulus(total);
    // Reset and the first idle cycle come on top
    cycle_limit = 2 * (total + 3);

    // Two reset cycles and a release off the clock edge
    repeat (2) @(posedge tck);
    #5;
    trst_pad_i = 1'b0;
    #90;
    check_idle(4'h0, 1'b1);

    for (int k = 0; k < op_q.size(); k++)
    begin
      if (op_q[k] == "irscan")
        scan_ir(k);
      else if (op_q[k] == "drscan")
        scan_dr(k);
      else
        force_reset_tms(k);
    end

    if (fail_count == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== tb_clock_gen.sv ====
// Testbench clock source
// Free-running clock, starts low, 100 ns period by default

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int period_ns = 100
) (
  output logic clk_o
);

  // Half period per phase
  initial
  begin
    clk_o = 1'b0;
    forever
      #(period_ns / 2) clk_o = ~clk_o;
  end

endmodule

// ==== jtag_tap.sv ====
// JTAG TAP controller top level
// Connects state machine, instruction register, data registers
// and TDO mux to the pads and the sub-chain ports

`timescale 1ns/1ps

module jtag_tap #(
  parameter jtag_pkg::idcode_t idcode_value = jtag_pkg::IDCODE_DEFAULT
) (
  // Pads
  input  logic tck_pad_i,
  input  logic trst_pad_i,
  input  logic tms_pad_i,
  input  logic tdi_pad_i,
  output logic tdo_pad_o,
  output logic tdo_padoe_o,
  // TAP states toward the chains
  output logic shift_dr_o,
  output logic pause_dr_o,
  output logic update_dr_o,
  output logic capture_dr_o,
  output logic test_logic_reset_o,
  // Chain selects
  output logic extest_select_o,
  output logic sample_preload_select_o,
  output logic mbist_select_o,
  output logic debug_select_o,
  // TDI of the sub-chains
  output logic tdo_o,
  // Returns from the sub-chains
  input  logic debug_tdi_i,
  input  logic bs_chain_tdi_i,
  input  logic mbist_tdi_i
);

  import jtag_pkg::*;

  ir_t  latched_ir;
  logic instruction_tdo;
  logic idcode_select;
  logic idcode_tdo;
  logic bypass_tdo;

  tap_state_if tap_st ();

  //////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////

  tap_fsm u_fsm (
    .tck_pad_i  (tck_pad_i),
    .trst_pad_i (trst_pad_i),
    .tms_pad_i  (tms_pad_i),
    .st         (tap_st.fsm_mp)
  );

  // Feedthru and bypass selects stay internal to the decode
  tap_instruction_reg u_ir (
    .tck_pad_i               (tck_pad_i),
    .trst_pad_i              (trst_pad_i),
    .tdi_pad_i               (tdi_pad_i),
    .st                      (tap_st.ir_mp),
    .latched_ir_o            (latched_ir),
    .instruction_tdo_o       (instruction_tdo),
    .extest_select_o         (extest_select_o),
    .sample_preload_select_o (sample_preload_select_o),
    .idcode_select_o         (idcode_select),
    .mbist_select_o          (mbist_select_o),
    .debug_select_o          (debug_select_o),
    .feedthru_select_o       (),
    .bypass_select_o         ()
  );

  tap_data_regs #(
    .idcode_value (idcode_value)
  ) u_dr (
    .tck_pad_i       (tck_pad_i),
    .trst_pad_i      (trst_pad_i),
    .tdi_pad_i       (tdi_pad_i),
    .idcode_select_i (idcode_select),
    .st              (tap_st.dr_mp),
    .idcode_tdo_o    (idcode_tdo),
    .bypass_tdo_o    (bypass_tdo)
  );

  tap_tdo_mux u_mux (
    .tck_pad_i         (tck_pad_i),
    .tdi_pad_i         (tdi_pad_i),
    .instruction_tdo_i (instruction_tdo),
    .idcode_tdo_i      (idcode_tdo),
    .bypass_tdo_i      (bypass_tdo),
    .debug_tdi_i       (debug_tdi_i),
    .bs_chain_tdi_i    (bs_chain_tdi_i),
    .mbist_tdi_i       (mbist_tdi_i),
    .debug_select_i    (debug_select_o),
    .latched_ir_i      (latched_ir),
    .st                (tap_st.mux_mp),
    .tdo_pad_o         (tdo_pad_o),
    .tdo_padoe_o       (tdo_padoe_o)
  );

  // State levels out to the chains
  assign shift_dr_o         = tap_st.shift_dr;
  assign pause_dr_o         = tap_st.pause_dr;
  assign update_dr_o        = tap_st.update_dr;
  assign capture_dr_o       = tap_st.capture_dr;
  assign test_logic_reset_o = tap_st.test_logic_reset;

  // TDI passed on to the first sub-chain
  assign tdo_o = tdi_pad_i;

endmodule

// ==== tap_tdo_mux.sv ====
// TDO source select and output enable
// Falling-edge copies of shift-IR and the active instruction
// steer the mux so TDO changes on the falling edge of TCK

`timescale 1ns/1ps

module tap_tdo_mux (
  input  logic          tck_pad_i,
  input  logic          tdi_pad_i,
  input  logic          instruction_tdo_i,
  input  logic          idcode_tdo_i,
  input  logic          bypass_tdo_i,
  input  logic          debug_tdi_i,
  input  logic          bs_chain_tdi_i,
  input  logic          mbist_tdi_i,
  input  logic          debug_select_i,
  input  jtag_pkg::ir_t latched_ir_i,
  tap_state_if.mux_mp   st,
  output logic          tdo_pad_o,
  output logic          tdo_padoe_o
);

  import jtag_pkg::*;

  logic shift_ir_neg;
  ir_t  latched_ir_neg;

  always_ff @(negedge tck_pad_i)
  begin
    shift_ir_neg   <= st.shift_ir;
    latched_ir_neg <= latched_ir_i;
  end

  // IR bits during an IR shift, else the chain named by the instruction
  always_comb
  begin
    if (shift_ir_neg)
      tdo_pad_o = instruction_tdo_i;
    else
    begin
      case (latched_ir_neg)
        INSTR_IDCODE:         tdo_pad_o = idcode_tdo_i;
        INSTR_DEBUG:          tdo_pad_o = debug_tdi_i;
        // Straight wire from TDI, no staging
        INSTR_FEEDTHRU:       tdo_pad_o = tdi_pad_i;
        INSTR_SAMPLE_PRELOAD: tdo_pad_o = bs_chain_tdi_i;
        INSTR_EXTEST:         tdo_pad_o = bs_chain_tdi_i;
        INSTR_MBIST:          tdo_pad_o = mbist_tdi_i;
        default:              tdo_pad_o = bypass_tdo_i;
      endcase
    end
  end

  // Pad driven while shifting, and in Pause-DR for the debug chain
  always_ff @(negedge tck_pad_i)
  begin
    tdo_padoe_o <= st.shift_ir | st.shift_dr | (st.pause_dr & debug_select_i);
  end

endmodule

// ==== tap_data_regs.sv ====
// IDCODE and bypass data registers
// Each with a falling-edge output stage toward the TDO mux

`timescale 1ns/1ps

module tap_data_regs #(
  parameter jtag_pkg::idcode_t idcode_value = jtag_pkg::IDCODE_DEFAULT
) (
  input  logic       tck_pad_i,
  input  logic       trst_pad_i,
  input  logic       tdi_pad_i,
  input  logic       idcode_select_i,
  tap_state_if.dr_mp st,
  output logic       idcode_tdo_o,
  output logic       bypass_tdo_o
);

  import jtag_pkg::*;

  idcode_t idcode_reg;
  logic    bypass_reg;

  // Shift only under IDCODE, otherwise keep the device code loaded
  always_ff @(posedge tck_pad_i)
  begin
    if (idcode_select_i && st.shift_dr)
      idcode_reg <= {tdi_pad_i, idcode_reg[31:1]};
    else
      idcode_reg <= idcode_value;
  end

  // Single-bit bypass stage
  always_ff @(posedge tck_pad_i or posedge trst_pad_i)
  begin
    if (trst_pad_i)
      bypass_reg <= 1'b0;
    else if (st.shift_dr)
      bypass_reg <= tdi_pad_i;
  end

  //////////////////////////////////////////////////
  // Falling-edge TDO stages
  //////////////////////////////////////////////////

  always_ff @(negedge tck_pad_i)
  begin
    idcode_tdo_o <= idcode_reg[0];
    bypass_tdo_o <= bypass_reg;
  end

endmodule

// ==== tap_instruction_reg.sv ====
// Instruction register
// Capture/shift register, update latch and instruction decode,
// plus the falling-edge copy of the IR LSB for TDO

`timescale 1ns/1ps

module tap_instruction_reg (
  input  logic           tck_pad_i,
  input  logic           trst_pad_i,
  input  logic           tdi_pad_i,
  tap_state_if.ir_mp     st,
  output jtag_pkg::ir_t  latched_ir_o,
  output logic           instruction_tdo_o,
  output logic           extest_select_o,
  output logic           sample_preload_select_o,
  output logic           idcode_select_o,
  output logic           mbist_select_o,
  output logic           debug_select_o,
  output logic           feedthru_select_o,
  output logic           bypass_select_o
);

  import jtag_pkg::*;

  ir_t ir_shift;

  // Capture loads the fixed pattern, shift moves right from TDI
  always_ff @(posedge tck_pad_i or posedge trst_pad_i)
  begin
    if (trst_pad_i)
      ir_shift <= '0;
    else if (st.capture_ir)
      ir_shift <= IR_CAPTURE_PATTERN;
    else if (st.shift_ir)
      ir_shift <= {tdi_pad_i, ir_shift[IR_LENGTH-1:1]};
  end

  // LSB toward TDO, half a cycle later
  always_ff @(negedge tck_pad_i)
  begin
    instruction_tdo_o <= ir_shift[0];
  end

  // Active instruction, IDCODE out of reset
  always_ff @(posedge tck_pad_i or posedge trst_pad_i)
  begin
    if (trst_pad_i)
      latched_ir_o <= INSTR_IDCODE;
    else if (st.test_logic_reset)
      latched_ir_o <= INSTR_IDCODE;
    else if (st.update_ir)
      latched_ir_o <= ir_shift;
  end

  //////////////////////////////////////////////////
  // Decode, one select high at a time
  //////////////////////////////////////////////////

  always_comb
  begin
    extest_select_o         = 1'b0;
    sample_preload_select_o = 1'b0;
    idcode_select_o         = 1'b0;
    mbist_select_o          = 1'b0;
    debug_select_o          = 1'b0;
    feedthru_select_o       = 1'b0;
    bypass_select_o         = 1'b0;
    case (latched_ir_o)
      INSTR_EXTEST:         extest_select_o         = 1'b1;
      INSTR_SAMPLE_PRELOAD: sample_preload_select_o = 1'b1;
      INSTR_IDCODE:         idcode_select_o         = 1'b1;
      INSTR_MBIST:          mbist_select_o          = 1'b1;
      INSTR_DEBUG:          debug_select_o          = 1'b1;
      INSTR_FEEDTHRU:       feedthru_select_o       = 1'b1;
      // BYPASS and every unused code
      default:              bypass_select_o         = 1'b1;
    endcase
  end

endmodule

// ==== tap_fsm.sv ====
// TAP controller state machine
// Sixteen-state IEEE 1149.1 sequencer, five-TMS-ones reset detector
// and decode of the state strobes

`timescale 1ns/1ps

module tap_fsm (
  input  logic tck_pad_i,
  input  logic trst_pad_i,
  input  logic tms_pad_i,
  tap_state_if.fsm_mp st
);

  import jtag_pkg::*;

  // Previous TMS samples, newest in bit 0
  logic [TMS_RESET_COUNT-2:0] tms_hist;
  logic                       tms_reset;

  tap_state_e state;
  tap_state_e state_next;

  //////////////////////////////////////////////////
  // Five-ones reset detector
  //////////////////////////////////////////////////

  always_ff @(posedge tck_pad_i or posedge trst_pad_i)
  begin
    if (trst_pad_i)
      tms_hist <= '0;
    else
      tms_hist <= {tms_hist[TMS_RESET_COUNT-3:0], tms_pad_i};
  end

  // Current TMS plus the four before it
  assign tms_reset = tms_pad_i & (&tms_hist);

  //////////////////////////////////////////////////
  // State transitions
  //////////////////////////////////////////////////

  always_comb
  begin
    case (state)
      TLR:      state_next = tms_pad_i ? TLR      : RTI;
      RTI:      state_next = tms_pad_i ? SEL_DR   : RTI;
      // DR column
      SEL_DR:   state_next = tms_pad_i ? SEL_IR   : CAP_DR;
      CAP_DR:   state_next = tms_pad_i ? EXIT1_DR : SHIFT_DR;
      SHIFT_DR: state_next = tms_pad_i ? EXIT1_DR : SHIFT_DR;
      EXIT1_DR: state_next = tms_pad_i ? UPD_DR   : PAUSE_DR;
      PAUSE_DR: state_next = tms_pad_i ? EXIT2_DR : PAUSE_DR;
      EXIT2_DR: state_next = tms_pad_i ? UPD_DR   : SHIFT_DR;
      UPD_DR:   state_next = tms_pad_i ? SEL_DR   : RTI;
      // IR column, Select-IR with TMS high falls back to reset
      SEL_IR:   state_next = tms_pad_i ? TLR      : CAP_IR;
      CAP_IR:   state_next = tms_pad_i ? EXIT1_IR : SHIFT_IR;
      SHIFT_IR: state_next = tms_pad_i ? EXIT1_IR : SHIFT_IR;
      EXIT1_IR: state_next = tms_pad_i ? UPD_IR   : PAUSE_IR;
      PAUSE_IR: state_next = tms_pad_i ? EXIT2_IR : PAUSE_IR;
      EXIT2_IR: state_next = tms_pad_i ? UPD_IR   : SHIFT_IR;
      UPD_IR:   state_next = tms_pad_i ? SEL_DR   : RTI;
    endcase
  end

  // Five ones win over the table from any state
  always_ff @(posedge tck_pad_i or posedge trst_pad_i)
  begin
    if (trst_pad_i)
      state <= TLR;
    else if (tms_reset)
      state <= TLR;
    else
      state <= state_next;
  end

  //////////////////////////////////////////////////
  // Strobes
  //////////////////////////////////////////////////

  assign st.test_logic_reset = (state == TLR);
  assign st.capture_dr       = (state == CAP_DR);
  assign st.shift_dr         = (state == SHIFT_DR);
  assign st.pause_dr         = (state == PAUSE_DR);
  assign st.update_dr        = (state == UPD_DR);
  assign st.capture_ir       = (state == CAP_IR);
  assign st.shift_ir         = (state == SHIFT_IR);
  assign st.update_ir        = (state == UPD_IR);

endmodule

// ==== tap_state_if.sv ====
// TAP state strobes
// One level per state of interest, high for the whole cycle in that state

`timescale 1ns/1ps

interface tap_state_if;

  logic test_logic_reset;
  logic capture_dr;
  logic shift_dr;
  logic pause_dr;
  logic update_dr;
  logic capture_ir;
  logic shift_ir;
  logic update_ir;

  // State machine side
  modport fsm_mp (
    output test_logic_reset, capture_dr, shift_dr, pause_dr, update_dr,
    output capture_ir, shift_ir, update_ir
  );

  // Instruction register side
  modport ir_mp (input test_logic_reset, capture_ir, shift_ir, update_ir);

  // Data registers only shift
  modport dr_mp (input shift_dr);

  // TDO mux and output enable
  modport mux_mp (input shift_ir, shift_dr, pause_dr);

endinterface

// ==== jtag_pkg.sv ====
// JTAG TAP shared definitions
// Register widths, instruction codes, capture pattern,
// default device code and the TAP state encoding

package jtag_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Instruction register length
  localparam int IR_LENGTH = 4;

  typedef logic [IR_LENGTH-1:0] ir_t;
  typedef logic [31:0]          idcode_t;

  //////////////////////////////////////////////////
  // Instruction codes
  //////////////////////////////////////////////////

  localparam ir_t INSTR_EXTEST         = 4'b0000;
  localparam ir_t INSTR_SAMPLE_PRELOAD = 4'b0001;
  localparam ir_t INSTR_IDCODE         = 4'b0010;
  localparam ir_t INSTR_DEBUG          = 4'b1000;
  localparam ir_t INSTR_MBIST          = 4'b1001;
  localparam ir_t INSTR_FEEDTHRU       = 4'b1100;
  localparam ir_t INSTR_BYPASS         = 4'b1111;

  // Fixed Capture-IR value with the LSB pair 01 that the standard requires
  localparam ir_t IR_CAPTURE_PATTERN = 4'b0101;

  // Version 1 and part C001 with manufacturer 0x6D6 and bit 0 set
  localparam idcode_t IDCODE_DEFAULT = 32'h1C001DAD;

  // Consecutive TMS ones that force Test-Logic-Reset
  localparam int TMS_RESET_COUNT = 5;

  //////////////////////////////////////////////////
  // TAP controller states
  //////////////////////////////////////////////////

  typedef enum logic [3:0] {
    TLR, RTI,
    SEL_DR, CAP_DR, SHIFT_DR, EXIT1_DR, PAUSE_DR, EXIT2_DR, UPD_DR,
    SEL_IR, CAP_IR, SHIFT_IR, EXIT1_IR, PAUSE_IR, EXIT2_IR, UPD_IR
  } tap_state_e;

endpackage
